//--- verilog/scu_pkg.sv
package scu_pkg;

    // ------------------------------
    // Field widths
    // ------------------------------
    localparam int unsigned SCU_DATA_W      = 4;
    localparam int unsigned SCU_OP_W        = 2;
    localparam int unsigned SCU_ADDR_W      = 2;
    // Op, then addr, then data in the low bits
    localparam int unsigned SCU_DR_W        = SCU_OP_W + SCU_ADDR_W + SCU_DATA_W;
    // Flops per status synchronizer
    localparam int unsigned SCU_SYNC_STAGES = 2;

    // Register operations
    typedef enum logic [SCU_OP_W-1:0] {
        OP_WRITE   = 2'd0,
        OP_READ    = 2'd1,
        OP_SETBITS = 2'd2,
        OP_CLRBITS = 2'd3
    } scu_op_e;

    // Register map
    typedef enum logic [SCU_ADDR_W-1:0] {
        ADDR_CONTROL = 2'd0,
        ADDR_MODE    = 2'd1,
        ADDR_STATUS  = 2'd2,
        ADDR_STICKY  = 2'd3
    } scu_addr_e;

    // Scan data register, LSB shifted out first
    typedef struct packed {
        scu_op_e               op;
        scu_addr_e             addr;
        logic [SCU_DATA_W-1:0] data;
    } scu_dr_s;

    // ------------------------------
    // One CSR word, three views
    // ------------------------------
    typedef struct packed {
        logic [1:0] spare;
        logic       core_reset;
        logic       sys_reset;
    } scu_ctrl_s;

    typedef struct packed {
        logic [1:0] spare;
        logic       hdu_rst_bhv;
        logic       dm_rst_bhv;
    } scu_mode_s;

    // 1 means the reset is asserted
    typedef struct packed {
        logic hdu;
        logic dm;
        logic core;
        logic sys;
    } scu_status_s;

    typedef union packed {
        scu_ctrl_s   ctrl;
        scu_mode_s   mode;
        scu_status_s status;
    } scu_csr_word_u;

endpackage

//--- verilog/scu_ifs.sv
// ------------------------------
// Scan chain to CSR file
// ------------------------------
interface csr_access_if;

    // Update strobe, one cycle
    logic                             upd;
    scu_pkg::scu_op_e                 op;
    scu_pkg::scu_addr_e               addr;
    // Operand from the shift register
    logic [scu_pkg::SCU_DATA_W-1:0]   data;
    // Outcome of the operation, combinational
    logic [scu_pkg::SCU_DATA_W-1:0]   result;

    modport chain (
        output upd,
        output op,
        output addr,
        output data,
        input  result
    );

    modport csr (
        input  upd,
        input  op,
        input  addr,
        input  data,
        output result
    );

endinterface

// ------------------------------
// CSR file to reset generator
// ------------------------------
interface rst_ctrl_if;

    // Registered CONTROL and MODE
    scu_pkg::scu_csr_word_u ctrl_word;
    scu_pkg::scu_csr_word_u mode_word;
    // Reset status, synchronized
    scu_pkg::scu_csr_word_u status_word;

    modport ctrl (
        output ctrl_word,
        output mode_word,
        input  status_word
    );

    modport gen (
        input  ctrl_word,
        input  mode_word,
        output status_word
    );

endinterface

//--- verilog/scu_rst_qlfy_cell.sv
module scu_rst_qlfy_cell (
    input  logic clk,
    input  logic pwrup_rst_n_sync,
    input  logic rst_n_in_i,
    output logic qlfy_o,
    output logic rst_n_o
);

    // Qualifier stage, then reset stage
    logic qlfy_ff;
    logic rst_n_ff;

    // Qualifier leads the reset by one cycle
    // on both edges
    always_ff @(posedge clk, negedge pwrup_rst_n_sync) begin
        if (~pwrup_rst_n_sync) begin
            qlfy_ff  <= 1'b0;
            rst_n_ff <= 1'b0;
        end else begin
            qlfy_ff  <= rst_n_in_i;
            rst_n_ff <= qlfy_ff;
        end
    end

    assign qlfy_o  = qlfy_ff;
    // Reset output doubles as status
    assign rst_n_o = rst_n_ff;

endmodule

//--- verilog/scu_scan_chain.sv
module scu_scan_chain (
    input  logic          clk,
    input  logic          pwrup_rst_n_sync,
    input  logic          ch_sel_i,
    input  logic          ch_capture_i,
    input  logic          ch_shift_i,
    input  logic          ch_update_i,
    input  logic          ch_tdi_i,
    output logic          ch_tdo_o,
    csr_access_if.chain   csr
);

    // Gated tap strobes
    logic             cap_req;
    logic             shft_req;
    logic             upd_req;

    // Shift and shadow registers
    scu_pkg::scu_dr_s shift_ff;
    scu_pkg::scu_dr_s shift_next;
    logic             shift_en;
    scu_pkg::scu_dr_s shadow_ff;

    // ------------------------------
    // Strobe decode
    // ------------------------------

    // Only act while this chain is selected
    assign cap_req  = ch_sel_i & ch_capture_i;
    assign shft_req = ch_sel_i & ch_shift_i;
    assign upd_req  = ch_sel_i & ch_update_i;

    // ------------------------------
    // Shift register
    // ------------------------------

    assign shift_en = cap_req | shft_req;

    // Capture wins over shift
    always_comb begin
        if (cap_req) begin
            shift_next = shadow_ff;
        end else begin
            // TDI enters at the MSB
            shift_next = {ch_tdi_i, shift_ff[scu_pkg::SCU_DR_W-1:1]};
        end
    end

    always_ff @(posedge clk, negedge pwrup_rst_n_sync) begin
        if (~pwrup_rst_n_sync) begin
            shift_ff <= '0;
        end else if (shift_en) begin
            shift_ff <= shift_next;
        end
    end

    // LSB goes out first
    assign ch_tdo_o = shift_ff[0];

    // ------------------------------
    // Shadow register
    // ------------------------------

    // Keeps op and addr, data becomes the operation result
    always_ff @(posedge clk, negedge pwrup_rst_n_sync) begin
        if (~pwrup_rst_n_sync) begin
            shadow_ff <= '0;
        end else if (upd_req) begin
            shadow_ff.op   <= shift_ff.op;
            shadow_ff.addr <= shift_ff.addr;
            shadow_ff.data <= csr.result;
        end
    end

    // Request towards the CSR file
    assign csr.upd  = upd_req;
    assign csr.op   = shift_ff.op;
    assign csr.addr = shift_ff.addr;
    assign csr.data = shift_ff.data;

endmodule

//--- verilog/scu_csr_file.sv
module scu_csr_file (
    input  logic        clk,
    input  logic        pwrup_rst_n_sync,
    csr_access_if.csr   acc,
    rst_ctrl_if.ctrl    rst
);

    // Stored registers
    scu_pkg::scu_csr_word_u          ctrl_ff;
    scu_pkg::scu_csr_word_u          mode_ff;
    logic [scu_pkg::SCU_DATA_W-1:0]  sticky_ff;

    // Status edge detect
    logic [scu_pkg::SCU_DATA_W-1:0]  status_dly;
    logic [scu_pkg::SCU_DATA_W-1:0]  status_rise;

    // Access path
    logic [scu_pkg::SCU_DATA_W-1:0]  rd_data;
    logic                            wr_req;
    logic                            ctrl_wr;
    logic                            mode_wr;
    logic                            sticky_wr;

    // ------------------------------
    // Read mux and result
    // ------------------------------

    always_comb begin
        rd_data = '0;
        case (acc.addr)
            scu_pkg::ADDR_CONTROL: rd_data = ctrl_ff;
            scu_pkg::ADDR_MODE:    rd_data = mode_ff;
            scu_pkg::ADDR_STATUS:  rd_data = rst.status_word;
            scu_pkg::ADDR_STICKY:  rd_data = sticky_ff;
        endcase
    end

    always_comb begin
        acc.result = rd_data;
        case (acc.op)
            scu_pkg::OP_WRITE:   acc.result = acc.data;
            scu_pkg::OP_READ:    acc.result = rd_data;
            scu_pkg::OP_SETBITS: acc.result = rd_data | acc.data;
            scu_pkg::OP_CLRBITS: acc.result = rd_data & ~acc.data;
        endcase
    end

    // ------------------------------
    // Write select
    // ------------------------------

    assign wr_req    = acc.upd & (acc.op != scu_pkg::OP_READ);
    assign ctrl_wr   = wr_req & (acc.addr == scu_pkg::ADDR_CONTROL);
    assign mode_wr   = wr_req & (acc.addr == scu_pkg::ADDR_MODE);
    // Sticky bits only clear from the debugger
    assign sticky_wr = acc.upd & (acc.op == scu_pkg::OP_CLRBITS)
                     & (acc.addr == scu_pkg::ADDR_STICKY);

    // CONTROL and MODE, spare bits included
    always_ff @(posedge clk, negedge pwrup_rst_n_sync) begin
        if (~pwrup_rst_n_sync) begin
            ctrl_ff <= '0;
            mode_ff <= '0;
        end else begin
            if (ctrl_wr) begin
                ctrl_ff <= acc.result;
            end
            if (mode_wr) begin
                mode_ff <= acc.result;
            end
        end
    end

    assign rst.ctrl_word = ctrl_ff;
    assign rst.mode_word = mode_ff;

    // ------------------------------
    // Sticky status
    // ------------------------------

    always_ff @(posedge clk, negedge pwrup_rst_n_sync) begin
        if (~pwrup_rst_n_sync) begin
            status_dly <= '0;
        end else begin
            status_dly <= rst.status_word;
        end
    end

    // Reset just asserted
    assign status_rise = rst.status_word & ~status_dly;

    // A new edge beats a clear in the same cycle
    always_ff @(posedge clk, negedge pwrup_rst_n_sync) begin
        if (~pwrup_rst_n_sync) begin
            sticky_ff <= '0;
        end else begin
            for (int i = 0; i < scu_pkg::SCU_DATA_W; i++) begin
                if (status_rise[i]) begin
                    sticky_ff[i] <= 1'b1;
                end else if (sticky_wr) begin
                    sticky_ff[i] <= acc.result[i];
                end
            end
        end
    end

endmodule

//--- verilog/scu_reset_gen.sv
module scu_reset_gen (
    input  logic       clk,
    input  logic       pwrup_rst_n_sync,
    input  logic       rst_n_i,
    input  logic       ndm_rst_n_i,
    input  logic       hart_rst_n_i,
    rst_ctrl_if.gen    rst,
    output logic       sys_rst_n_o,
    output logic       core_rst_n_o,
    output logic       dm_rst_n_o,
    output logic       hdu_rst_n_o,
    output logic       sys_rdc_qlfy_o,
    output logic       core_rdc_qlfy_o,
    output logic       hdu2dm_rdc_qlfy_o
);

    // Cell inputs, active low
    logic                                    sys_rst_n_in;
    logic                                    core_rst_n_in;
    logic                                    hdu_rst_n_in;
    logic                                    dm_rst_n_in;
    logic                                    dm_rst_n_ff;

    // Status syncs for sys, core, hdu
    logic [2:0]                              sync_in;
    logic [2:0][scu_pkg::SCU_SYNC_STAGES-1:0] sync_ff;
    scu_pkg::scu_csr_word_u                  status_w;

    // ------------------------------
    // Reset equations
    // ------------------------------

    // Debugger request, non-DM reset, regular reset
    assign sys_rst_n_in  = ~rst.ctrl_word.ctrl.sys_reset & ndm_rst_n_i & rst_n_i;
    // Core also follows hart reset and its own bit
    assign core_rst_n_in = sys_rst_n_in & hart_rst_n_i & ~rst.ctrl_word.ctrl.core_reset;
    // HDU may be kept out of core reset
    assign hdu_rst_n_in  = rst.mode_word.mode.hdu_rst_bhv | core_rst_n_in;
    // DM only reset by sys_reset when enabled
    assign dm_rst_n_in   = ~rst.mode_word.mode.dm_rst_bhv | ~rst.ctrl_word.ctrl.sys_reset;

    // ------------------------------
    // Qualified resets
    // ------------------------------

    scu_rst_qlfy_cell u_sys (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .rst_n_in_i       (sys_rst_n_in),
        .qlfy_o           (sys_rdc_qlfy_o),
        .rst_n_o          (sys_rst_n_o)
    );

    scu_rst_qlfy_cell u_core (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .rst_n_in_i       (core_rst_n_in),
        .qlfy_o           (core_rdc_qlfy_o),
        .rst_n_o          (core_rst_n_o)
    );

    scu_rst_qlfy_cell u_hdu (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .rst_n_in_i       (hdu_rst_n_in),
        .qlfy_o           (hdu2dm_rdc_qlfy_o),
        .rst_n_o          (hdu_rst_n_o)
    );

    // DM reset buffer, one flop
    always_ff @(posedge clk, negedge pwrup_rst_n_sync) begin
        if (~pwrup_rst_n_sync) begin
            dm_rst_n_ff <= 1'b0;
        end else begin
            dm_rst_n_ff <= dm_rst_n_in;
        end
    end

    assign dm_rst_n_o = dm_rst_n_ff;

    // ------------------------------
    // Status synchronizers
    // ------------------------------

    // Asserted resets as ones
    assign sync_in = {~hdu_rst_n_o, ~core_rst_n_o, ~sys_rst_n_o};

    // Clears to "no reset"
    always_ff @(posedge clk, negedge pwrup_rst_n_sync) begin
        if (~pwrup_rst_n_sync) begin
            sync_ff <= '0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                sync_ff[i] <= {sync_ff[i][scu_pkg::SCU_SYNC_STAGES-2:0], sync_in[i]};
            end
        end
    end

    always_comb begin
        status_w             = '0;
        status_w.status.sys  = sync_ff[0][scu_pkg::SCU_SYNC_STAGES-1];
        status_w.status.core = sync_ff[1][scu_pkg::SCU_SYNC_STAGES-1];
        status_w.status.hdu  = sync_ff[2][scu_pkg::SCU_SYNC_STAGES-1];
        // Already in this domain
        status_w.status.dm   = ~dm_rst_n_ff;
    end

    assign rst.status_word = status_w;

endmodule

//--- verilog/scu_top.sv
module scu_top (
    input  logic clk,
    input  logic pwrup_rst_n_sync,

    // External reset requests
    input  logic rst_n_i,
    input  logic ndm_rst_n_i,
    input  logic hart_rst_n_i,

    // Tap chain
    input  logic ch_sel_i,
    input  logic ch_capture_i,
    input  logic ch_shift_i,
    input  logic ch_update_i,
    input  logic ch_tdi_i,
    output logic ch_tdo_o,

    // Generated resets
    output logic sys_rst_n_o,
    output logic core_rst_n_o,
    output logic dm_rst_n_o,
    output logic hdu_rst_n_o,

    // Synchronized status, 1 is in reset
    output logic sys_rst_status_o,
    output logic core_rst_status_o,

    // RDC qualifiers
    output logic sys_rdc_qlfy_o,
    output logic core_rdc_qlfy_o,
    output logic hdu2dm_rdc_qlfy_o
);

    csr_access_if u_csr_bus ();
    rst_ctrl_if   u_rst_bus ();

    // ------------------------------
    // Debugger access path
    // ------------------------------

    scu_scan_chain u_scan_chain (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .ch_sel_i         (ch_sel_i),
        .ch_capture_i     (ch_capture_i),
        .ch_shift_i       (ch_shift_i),
        .ch_update_i      (ch_update_i),
        .ch_tdi_i         (ch_tdi_i),
        .ch_tdo_o         (ch_tdo_o),
        .csr              (u_csr_bus.chain)
    );

    // Sits between chain and reset logic
    scu_csr_file u_csr_file (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .acc              (u_csr_bus.csr),
        .rst              (u_rst_bus.ctrl)
    );

    // ------------------------------
    // Reset generation
    // ------------------------------

    scu_reset_gen u_reset_gen (
        .clk               (clk),
        .pwrup_rst_n_sync  (pwrup_rst_n_sync),
        .rst_n_i           (rst_n_i),
        .ndm_rst_n_i       (ndm_rst_n_i),
        .hart_rst_n_i      (hart_rst_n_i),
        .rst               (u_rst_bus.gen),
        .sys_rst_n_o       (sys_rst_n_o),
        .core_rst_n_o      (core_rst_n_o),
        .dm_rst_n_o        (dm_rst_n_o),
        .hdu_rst_n_o       (hdu_rst_n_o),
        .sys_rdc_qlfy_o    (sys_rdc_qlfy_o),
        .core_rdc_qlfy_o   (core_rdc_qlfy_o),
        .hdu2dm_rdc_qlfy_o (hdu2dm_rdc_qlfy_o)
    );

    // Status view of the shared word
    assign sys_rst_status_o  = u_rst_bus.status_word.status.sys;
    assign core_rst_status_o = u_rst_bus.status_word.status.core;

endmodule

//--- testbench/tb_scu_tasks.svh
// ------------------------------
// Register model
// ------------------------------

// Expected CONTROL, MODE, STATUS and STICKY contents
logic [DATA_W-1:0] m_ctrl;
logic [DATA_W-1:0] m_mode;
logic [DATA_W-1:0] m_status;
logic [DATA_W-1:0] m_sticky;
// Shadow contents the next capture returns
logic [DR_W-1:0]   prev_dr;
logic [31:0]       rng_state;

task automatic model_init();
    m_ctrl    = '0;
    m_mode    = '0;
    m_status  = '0;
    m_sticky  = '0;
    // Shadow clears to a write of 0 to CONTROL
    prev_dr   = '0;
    rng_state = 32'h38bf2864;
endtask

// Operand of an operation
function automatic logic [DATA_W-1:0] model_value(input scu_pkg::scu_addr_e addr);
    case (addr)
        scu_pkg::ADDR_CONTROL: return m_ctrl;
        scu_pkg::ADDR_MODE:    return m_mode;
        // 1 is in reset
        scu_pkg::ADDR_STATUS:  return m_status;
        default:               return m_sticky;
    endcase
endfunction

function automatic logic [DATA_W-1:0] op_result(input scu_pkg::scu_op_e op,
                                                input logic [DATA_W-1:0] cur,
                                                input logic [DATA_W-1:0] data);
    case (op)
        scu_pkg::OP_WRITE:   return data;
        scu_pkg::OP_READ:    return cur;
        scu_pkg::OP_SETBITS: return cur | data;
        default:             return cur & ~data;
    endcase
endfunction

// ------------------------------
// Random data
// ------------------------------

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

function automatic logic [DATA_W-1:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state[DATA_W-1:0];
endfunction

// ------------------------------
// Scan chain access
// ------------------------------

// Advance to just after the next drive point
task automatic step(input int n);
    repeat (n) begin
        @(posedge clk);
        #DRV_DLY;
    end
endtask

// Capture, shift, update; checks the outcome of the previous op
task automatic scan_op(input scu_pkg::scu_op_e op, input scu_pkg::scu_addr_e addr,
                       input logic [DATA_W-1:0] data, output logic [DR_W-1:0] dr_out);
    logic [DR_W-1:0]   dr_in;
    logic [DATA_W-1:0] cur;
    logic [DATA_W-1:0] res;
    dr_in = {op, addr, data};
    ch_capture_i = 1'b1;
    step(1);
    ch_capture_i = 1'b0;
    // LSB first, both directions
    for (int i = 0; i < DR_W; i++) begin
        dr_out[i]  = ch_tdo_o;
        ch_tdi_i   = dr_in[i];
        ch_shift_i = 1'b1;
        step(1);
    end
    ch_shift_i = 1'b0;
    // Operand as it stands at the update edge
    cur = model_value(addr);
    res = op_result(op, cur, data);
    ch_update_i = 1'b1;
    step(1);
    ch_update_i = 1'b0;
    assert (dr_out === prev_dr)
    else begin
        errors++;
        $display("** Error at %0t: scan out %h, expected %h", $time, dr_out, prev_dr);
    end
    prev_dr = {op, addr, res};
    // Commit to the model
    if (op != scu_pkg::OP_READ && addr == scu_pkg::ADDR_CONTROL) begin
        m_ctrl = res;
    end
    if (op != scu_pkg::OP_READ && addr == scu_pkg::ADDR_MODE) begin
        m_mode = res;
    end
    if (op == scu_pkg::OP_CLRBITS && addr == scu_pkg::ADDR_STICKY) begin
        m_sticky = res;
    end
endtask

task automatic scan_read(input scu_pkg::scu_addr_e addr, output logic [DR_W-1:0] dr_out);
    scan_op(scu_pkg::OP_READ, addr, '0, dr_out);
endtask

// Random write, set, clear, then a read
task automatic exercise_reg(input scu_pkg::scu_addr_e addr);
    logic [DR_W-1:0] dr;
    scan_op(scu_pkg::OP_WRITE, addr, next_rand(), dr);
    scan_op(scu_pkg::OP_SETBITS, addr, next_rand(), dr);
    scan_op(scu_pkg::OP_CLRBITS, addr, next_rand(), dr);
    scan_read(addr, dr);
endtask

//--- testbench/tb_scu.sv
module tb_scu;

    // ------------------------------
    // Timing and run length
    // ------------------------------
    localparam int CLK_PERIOD = 100;
    localparam int DRV_DLY    = 10;
    localparam int RESET_CYC  = 16;
    localparam int DR_W       = scu_pkg::SCU_DR_W;
    localparam int DATA_W     = scu_pkg::SCU_DATA_W;
    // Capture, shifts, update
    localparam int SCAN_CYC   = DR_W + 2;
    localparam int SCAN_OPS   = 32;
    localparam int WAIT_CALLS = 16;
    localparam int WAIT_MAX   = 8;
    localparam int TIMEOUT_CYC = RESET_CYC + SCAN_OPS * SCAN_CYC + WAIT_CALLS * WAIT_MAX + 20;

    // Output bits in the observation vector
    localparam logic [8:0] OBS_SYS     = 9'h001;
    localparam logic [8:0] OBS_CORE    = 9'h002;
    localparam logic [8:0] OBS_DM      = 9'h004;
    localparam logic [8:0] OBS_ST_SYS  = 9'h080;
    localparam logic [8:0] OBS_ST_CORE = 9'h100;
    // All resets and qualifiers high
    localparam logic [8:0] OBS_UP      = 9'h07f;
    localparam logic [8:0] OBS_ALL     = 9'h1ff;

    logic clk;
    logic pwrup_rst_n_sync;
    logic rst_n_i, ndm_rst_n_i, hart_rst_n_i;
    logic ch_sel_i, ch_capture_i, ch_shift_i, ch_update_i, ch_tdi_i;
    logic ch_tdo_o;
    logic sys_rst_n_o, core_rst_n_o, dm_rst_n_o, hdu_rst_n_o;
    logic sys_rst_status_o, core_rst_status_o;
    logic sys_rdc_qlfy_o, core_rdc_qlfy_o, hdu2dm_rdc_qlfy_o;
    logic [8:0] obs;

    int   errors;
    int   test_err0;
    int   tests_run;
    int   tests_failed;
    int   cycles;
    // Enables for the hold checks
    logic hdu_hold;
    logic dm_hold;

    scu_top dut (
        .clk               (clk),
        .pwrup_rst_n_sync  (pwrup_rst_n_sync),
        .rst_n_i           (rst_n_i),
        .ndm_rst_n_i       (ndm_rst_n_i),
        .hart_rst_n_i      (hart_rst_n_i),
        .ch_sel_i          (ch_sel_i),
        .ch_capture_i      (ch_capture_i),
        .ch_shift_i        (ch_shift_i),
        .ch_update_i       (ch_update_i),
        .ch_tdi_i          (ch_tdi_i),
        .ch_tdo_o          (ch_tdo_o),
        .sys_rst_n_o       (sys_rst_n_o),
        .core_rst_n_o      (core_rst_n_o),
        .dm_rst_n_o        (dm_rst_n_o),
        .hdu_rst_n_o       (hdu_rst_n_o),
        .sys_rst_status_o  (sys_rst_status_o),
        .core_rst_status_o (core_rst_status_o),
        .sys_rdc_qlfy_o    (sys_rdc_qlfy_o),
        .core_rdc_qlfy_o   (core_rdc_qlfy_o),
        .hdu2dm_rdc_qlfy_o (hdu2dm_rdc_qlfy_o)
    );

    assign obs = {core_rst_status_o, sys_rst_status_o, hdu2dm_rdc_qlfy_o, core_rdc_qlfy_o,
                  sys_rdc_qlfy_o, hdu_rst_n_o, dm_rst_n_o, core_rst_n_o, sys_rst_n_o};

    `include "tb_scu_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYC) begin
            $display("Run did not finish within %0d cycles, stopping", TIMEOUT_CYC);
            $display("Test FAILED");
            $finish;
        end
    end

    // ------------------------------
    // Concurrent checks
    // ------------------------------

    // Qualifier low one cycle ahead of each falling reset
    a_sys_qlfy: assert property (@(posedge clk) disable iff (!pwrup_rst_n_sync)
        $fell(sys_rst_n_o) |-> $past(!sys_rdc_qlfy_o))
    else begin
        errors++;
        $display("** Error at %0t: sys_rst_n_o fell with its qualifier still high", $time);
    end

    a_core_qlfy: assert property (@(posedge clk) disable iff (!pwrup_rst_n_sync)
        $fell(core_rst_n_o) |-> $past(!core_rdc_qlfy_o))
    else begin
        errors++;
        $display("** Error at %0t: core_rst_n_o fell with its qualifier still high", $time);
    end

    a_hdu_qlfy: assert property (@(posedge clk) disable iff (!pwrup_rst_n_sync)
        $fell(hdu_rst_n_o) |-> $past(!hdu2dm_rdc_qlfy_o))
    else begin
        errors++;
        $display("** Error at %0t: hdu_rst_n_o fell with its qualifier still high", $time);
    end

    // HDU kept out of core reset
    a_hdu_hold: assert property (@(posedge clk) disable iff (!pwrup_rst_n_sync)
        hdu_hold |-> hdu_rst_n_o)
    else begin
        errors++;
        $display("** Error at %0t: hdu_rst_n_o low with hdu_rst_bhv set", $time);
    end

    // DM left alone when dm_rst_bhv is clear
    a_dm_hold: assert property (@(posedge clk) disable iff (!pwrup_rst_n_sync)
        dm_hold |-> dm_rst_n_o)
    else begin
        errors++;
        $display("** Error at %0t: dm_rst_n_o low with dm_rst_bhv clear", $time);
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    // Waits up to max_cyc cycles for the masked outputs
    task automatic wait_obs(input logic [8:0] mask, input logic [8:0] value,
                            input int max_cyc, input string what);
        int n;
        n = 0;
        while (((obs & mask) !== value) && (n < max_cyc)) begin
            step(1);
            n++;
        end
        assert ((obs & mask) === value)
        else begin
            errors++;
            $display("** Error at %0t: %s, outputs %h, expected %h under mask %h",
                     $time, what, obs, value, mask);
        end
    endtask

    task automatic start_test();
        test_err0 = errors;
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (errors == test_err0) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name, errors - test_err0);
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------

    initial begin
        logic [DR_W-1:0] dr;
        pwrup_rst_n_sync = 1'b0;
        rst_n_i          = 1'b1;
        ndm_rst_n_i      = 1'b1;
        hart_rst_n_i     = 1'b1;
        ch_sel_i         = 1'b1;
        ch_capture_i     = 1'b0;
        ch_shift_i       = 1'b0;
        ch_update_i      = 1'b0;
        ch_tdi_i         = 1'b0;
        hdu_hold         = 1'b0;
        dm_hold          = 1'b0;
        errors           = 0;
        tests_run        = 0;
        tests_failed     = 0;
        cycles           = 0;
        model_init();
        step(RESET_CYC);
        pwrup_rst_n_sync = 1'b1;

        // Power-up release
        start_test();
        wait_obs(OBS_ALL, OBS_UP, 8, "outputs after power-up release");
        close_test("power-up release");

        // Random register traffic
        start_test();
        exercise_reg(scu_pkg::ADDR_CONTROL);
        exercise_reg(scu_pkg::ADDR_MODE);
        scan_op(scu_pkg::OP_WRITE, scu_pkg::ADDR_CONTROL, 4'b0000, dr);
        scan_op(scu_pkg::OP_WRITE, scu_pkg::ADDR_MODE, 4'b0000, dr);
        wait_obs(OBS_UP, OBS_UP, 8, "resets after clearing CONTROL and MODE");
        close_test("register operations");

        // Reset chain and qualifiers
        start_test();
        scan_op(scu_pkg::OP_SETBITS, scu_pkg::ADDR_CONTROL, 4'b0001, dr);
        wait_obs(OBS_ST_SYS, OBS_ST_SYS, 8, "sys status after sys_reset set");
        scan_op(scu_pkg::OP_CLRBITS, scu_pkg::ADDR_CONTROL, 4'b0001, dr);
        wait_obs(OBS_UP, OBS_UP, 8, "resets after sys_reset cleared");
        scan_op(scu_pkg::OP_SETBITS, scu_pkg::ADDR_CONTROL, 4'b0010, dr);
        wait_obs(OBS_CORE, 9'h000, 8, "core reset after core_reset set");
        scan_op(scu_pkg::OP_CLRBITS, scu_pkg::ADDR_CONTROL, 4'b0010, dr);
        wait_obs(OBS_UP, OBS_UP, 8, "resets after core_reset cleared");
        hart_rst_n_i = 1'b0;
        wait_obs(OBS_CORE, 9'h000, 8, "core reset from hart reset");
        hart_rst_n_i = 1'b1;
        wait_obs(OBS_UP, OBS_UP, 8, "resets after hart reset released");
        close_test("reset chaining");

        // Mode bits
        start_test();
        scan_op(scu_pkg::OP_WRITE, scu_pkg::ADDR_MODE, 4'b0010, dr);
        hdu_hold = 1'b1;
        scan_op(scu_pkg::OP_SETBITS, scu_pkg::ADDR_CONTROL, 4'b0010, dr);
        wait_obs(OBS_CORE, 9'h000, 8, "core reset with HDU kept out");
        scan_op(scu_pkg::OP_CLRBITS, scu_pkg::ADDR_CONTROL, 4'b0010, dr);
        wait_obs(OBS_UP, OBS_UP, 8, "resets after core reset with HDU kept out");
        hdu_hold = 1'b0;
        scan_op(scu_pkg::OP_WRITE, scu_pkg::ADDR_MODE, 4'b0001, dr);
        scan_op(scu_pkg::OP_SETBITS, scu_pkg::ADDR_CONTROL, 4'b0001, dr);
        wait_obs(OBS_DM, 9'h000, 3, "DM reset with dm_rst_bhv set");
        scan_op(scu_pkg::OP_CLRBITS, scu_pkg::ADDR_CONTROL, 4'b0001, dr);
        wait_obs(OBS_UP, OBS_UP, 8, "resets after DM reset");
        scan_op(scu_pkg::OP_WRITE, scu_pkg::ADDR_MODE, 4'b0000, dr);
        dm_hold = 1'b1;
        scan_op(scu_pkg::OP_SETBITS, scu_pkg::ADDR_CONTROL, 4'b0001, dr);
        wait_obs(OBS_SYS, 9'h000, 8, "sys reset with DM left alone");
        scan_op(scu_pkg::OP_CLRBITS, scu_pkg::ADDR_CONTROL, 4'b0001, dr);
        wait_obs(OBS_UP, OBS_UP, 8, "resets after sys reset with DM left alone");
        dm_hold = 1'b0;
        close_test("reset behavior modes");

        // Status and sticky bits
        start_test();
        scan_op(scu_pkg::OP_CLRBITS, scu_pkg::ADDR_STICKY, 4'b1111, dr);
        scan_op(scu_pkg::OP_SETBITS, scu_pkg::ADDR_CONTROL, 4'b0001, dr);
        wait_obs(OBS_ST_SYS | OBS_ST_CORE, OBS_ST_SYS | OBS_ST_CORE, 8,
                 "sys and core status during pulse");
        // Pulse hits sys, core and HDU, DM stays out with MODE clear
        m_status = 4'b1011;
        m_sticky = m_sticky | 4'b1011;
        scan_read(scu_pkg::ADDR_STATUS, dr);
        scan_op(scu_pkg::OP_CLRBITS, scu_pkg::ADDR_CONTROL, 4'b0001, dr);
        wait_obs(OBS_UP, OBS_UP, 8, "resets after the pulse");
        // All resets released again
        m_status = 4'b0000;
        scan_read(scu_pkg::ADDR_STICKY, dr);
        scan_op(scu_pkg::OP_WRITE, scu_pkg::ADDR_STICKY, 4'b0000, dr);
        scan_op(scu_pkg::OP_CLRBITS, scu_pkg::ADDR_STICKY, 4'b0001, dr);
        scan_read(scu_pkg::ADDR_STICKY, dr);
        // Flush of the last result
        scan_read(scu_pkg::ADDR_CONTROL, dr);
        close_test("status and sticky");

        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+testbench
verilog/scu_pkg.sv
verilog/scu_ifs.sv
verilog/scu_rst_qlfy_cell.sv
verilog/scu_scan_chain.sv
verilog/scu_csr_file.sv
verilog/scu_reset_gen.sv
verilog/scu_top.sv
testbench/tb_scu.sv

//--- Makefile
# Verilator build and run for the system control unit testbench

VERILATOR ?= verilator
TOP       ?= tb_scu
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test OK

SRCS := $(wildcard verilog/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
